// ==== Makefile ====
# Verilator flow for the spectral path testbench
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := spectral_tb
FILELIST  := files.f
OBJ_DIR   := obj_dir
PASS_MSG  := Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/spectral_tasks.svh ====
// spectral path testbench helpers
// APB access tasks, xorshift generator, bit-reverse and Q15 models,
// and the tasks that play the two FFT cores on the stream ports
`ifndef SPECTRAL_TASKS_SVH
`define SPECTRAL_TASKS_SVH

// xorshift32, state kept in the testbench
function automatic word_t next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

// index bits mirrored, MSB becomes LSB
function automatic bin_index_t reverse_bits6(input bin_index_t idx);
    return {idx[0], idx[1], idx[2], idx[3], idx[4], idx[5]};
endfunction

// Q15 product, bits 30:15 of the full signed result
function automatic sample_t q15_scale(input sample_t gain, input sample_t bin);
    logic signed [31:0] product;
    product = $signed(gain) * $signed(bin);
    return product[30:15];
endfunction

function automatic apb_addr_t window_addr(input apb_addr_t base, input int k);
    return base + apb_addr_t'(k * 4);
endfunction

// setup phase, then access phase sampled mid-cycle
task apb_write(input apb_addr_t addr, input word_t data, output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(posedge clock);
    #DRIVE_DELAY;
    penable = 1'b1;
    #(SAMPLE_DELAY);
    err = pslverr;
    @(posedge clock);
    #DRIVE_DELAY;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
endtask

task apb_read(input apb_addr_t addr, output word_t data, output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(posedge clock);
    #DRIVE_DELAY;
    penable = 1'b1;
    #(SAMPLE_DELAY);
    data = prdata;
    err  = pslverr;
    @(posedge clock);
    #DRIVE_DELAY;
    psel    = 1'b0;
    penable = 1'b0;
endtask

// core input side, one sample per cycle for 64 cycles
task follow_feed(input logic inverse);
    logic    en;
    sample_t data;
    sample_t exp;
    for (int i = 0; i < NUM_BINS; i++) begin
        #(SAMPLE_DELAY);
        en   = inverse ? inv_in_en : fwd_in_en;
        data = inverse ? inv_in_im : fwd_in_re;
        exp  = inverse ? mod_exp[i] : sample_exp[i];
        if (!en) begin
            note_failure($sformatf("feed enable low at sample %0d", i));
        end else if (data !== exp) begin
            note_failure($sformatf("feed sample %0d is %h, expected %h", i, data, exp));
        end
        @(posedge clock);
        #DRIVE_DELAY;
    end
    #(SAMPLE_DELAY);
    en = inverse ? inv_in_en : fwd_in_en;
    if (en) begin
        note_failure("feed enable still high after 64 samples");
    end
    @(posedge clock);
    #DRIVE_DELAY;
endtask

// core output side, 64 beats with random idle gaps of 0 to 3 cycles
task play_beats(input logic inverse);
    word_t rnd;
    int    gap;
    for (int i = 0; i < NUM_BINS; i++) begin
        rnd = next_random();
        gap = int'(rnd[1:0]);
        repeat (gap) begin
            @(posedge clock);
            #DRIVE_DELAY;
        end
        if (inverse) begin
            inv_out_en = 1'b1;
            inv_out_re = inv_beats[i];
        end else begin
            fwd_out_en = 1'b1;
            fwd_out_im = fwd_beats[i];
        end
        @(posedge clock);
        #DRIVE_DELAY;
        fwd_out_en = 1'b0;
        inv_out_en = 1'b0;
    end
endtask

// poll STATUS until busy clears
task wait_idle(input string what);
    word_t status;
    logic  err;
    int    polls;
    status = 32'h1;
    polls  = 0;
    while (status[0] && polls < IDLE_POLLS) begin
        apb_read(ADDR_STATUS, status, err);
        polls++;
    end
    if (status[0]) begin
        report_timeout($sformatf("busy to fall after %s", what));
    end
endtask

`endif

// ==== bench/spectral_tb.sv ====
// testbench for the spectral processing top level
// drives commands over APB, plays the forward and inverse FFT cores
// and compares feeds, captures and error responses with models
`timescale 1ns/1ps

module spectral_tb
    import spectral_pkg::*;
();

    localparam int CLOCK_HALF   = 20;
    localparam int DRIVE_DELAY  = 2;
    localparam int SAMPLE_DELAY = 18;
    localparam int IDLE_POLLS   = 200;
    localparam int FEED_WAIT    = 200;

    typedef struct packed {
        band_t   band;
        sample_t gain;
    } gain_case_t;

    typedef struct packed {
        apb_addr_t addr;
        logic      write;
        logic      expect_err;
    } err_case_t;

    logic      clock;
    logic      fft_reset;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    word_t     pwdata;
    word_t     prdata;
    logic      pready;
    logic      pslverr;
    logic      fwd_in_en;
    sample_t   fwd_in_re;
    logic      fwd_out_en;
    sample_t   fwd_out_im;
    logic      inv_in_en;
    sample_t   inv_in_im;
    logic      inv_out_en;
    sample_t   inv_out_re;

    // model of every memory window
    sample_t sample_exp [NUM_BINS];
    sample_t bin_exp    [NUM_BINS];
    sample_t mod_exp    [NUM_BINS];
    sample_t result_exp [NUM_BINS];
    // beats played on the core outputs
    sample_t fwd_beats  [NUM_BINS];
    sample_t inv_beats  [NUM_BINS];

    gain_case_t gain_cases [5];
    err_case_t  err_cases  [8];

    word_t rng_state;
    int    error_count;
    int    tests_run;
    int    tests_failed;
    int    errors_at_start;
    string test_name;

    task note_failure(input string msg);
        error_count++;
        $display("FAILED at %0t: %s", $time, msg);
    endtask

    task report_timeout(input string what);
        error_count++;
        $display("timeout at %0t while waiting for %s", $time, what);
    endtask

    task begin_test(input string name);
        test_name       = name;
        errors_at_start = error_count;
        tests_run++;
    endtask

    task end_test();
        if (error_count == errors_at_start) begin
            $display("test %0d %s: ok", tests_run, test_name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, test_name,
                     error_count - errors_at_start);
        end
    endtask

    `include "spectral_tasks.svh"

    // one window entry, zero-extended into the data word
    task check_entry(input apb_addr_t base, input int k, input sample_t exp, input string name);
        word_t rdata;
        logic  err;
        apb_read(window_addr(base, k), rdata, err);
        if (err || rdata !== {16'h0000, exp}) begin
            note_failure($sformatf("%s[%0d] read %h err %b, expected %h",
                                   name, k, rdata, err, exp));
        end
    endtask

    task verify_windows();
        for (int k = 0; k < NUM_BINS; k++) begin
            check_entry(BASE_SAMPLE, k, sample_exp[k], "SAMPLE");
            check_entry(BASE_BIN, k, bin_exp[k], "BIN");
            check_entry(BASE_MOD, k, mod_exp[k], "MOD");
            check_entry(BASE_RESULT, k, result_exp[k], "RESULT");
        end
    endtask

    spectral_top i_spectral_top (.*);

    initial begin
        clock = 1'b0;
        forever #(CLOCK_HALF) clock = ~clock;
    end

    initial begin
        word_t rnd;
        word_t rdata;
        logic  err;
        int    band_num;
        int    base;
        int    tries;
        fft_reset  = 1'b1;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        fwd_out_en = 1'b0;
        fwd_out_im = '0;
        inv_out_en = 1'b0;
        inv_out_re = '0;
        rng_state    = 32'h3043e861;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int k = 0; k < NUM_BINS; k++) begin
            sample_exp[k] = '0;
            bin_exp[k]    = '0;
            mod_exp[k]    = '0;
            result_exp[k] = '0;
        end
        // band 0 in the field selects band 16, band 3 is rewritten
        gain_cases = '{
            '{4'd1, 16'h4000},
            '{4'd3, 16'h8000},
            '{4'd7, 16'h7fff},
            '{4'd0, 16'hc000},
            '{4'd3, 16'h2000}
        };
        // address, write, expected pslverr
        err_cases = '{
            '{12'h200, 1'b1, 1'b1},
            '{12'h304, 1'b1, 1'b1},
            '{12'h41c, 1'b1, 1'b1},
            '{12'h004, 1'b1, 1'b1},
            '{12'h800, 1'b1, 1'b1},
            '{12'h010, 1'b0, 1'b1},
            '{12'h102, 1'b1, 1'b1},
            '{12'h000, 1'b0, 1'b0}
        };
        repeat (5) @(posedge clock);
        #DRIVE_DELAY;
        fft_reset = 1'b0;
        @(posedge clock);
        #DRIVE_DELAY;

        begin_test("reset state");
        #(SAMPLE_DELAY);
        if (fwd_in_en || inv_in_en || pslverr || !pready) begin
            note_failure("stream enables, pslverr or pready wrong after reset");
        end
        @(posedge clock);
        #DRIVE_DELAY;
        check_entry(ADDR_STATUS, 0, 16'h0000, "STATUS");
        verify_windows();
        end_test();

        begin_test("sample feed");
        for (int k = 0; k < NUM_BINS; k++) begin
            rnd           = next_random();
            sample_exp[k] = rnd[15:0];
            apb_write(window_addr(BASE_SAMPLE, k), {16'h0000, sample_exp[k]}, err);
            if (err) begin
                note_failure($sformatf("sample write %0d refused", k));
            end
        end
        apb_write(ADDR_CTRL, word_t'(CMD_FORWARD), err);
        if (err) begin
            note_failure("forward command refused");
        end
        // feed starts right after the access phase
        follow_feed(1'b0);
        end_test();

        begin_test("forward capture");
        for (int k = 0; k < NUM_BINS; k++) begin
            rnd          = next_random();
            fwd_beats[k] = rnd[15:0];
        end
        play_beats(1'b0);
        wait_idle("forward capture");
        for (int k = 0; k < NUM_BINS; k++) begin
            bin_exp[k] = fwd_beats[reverse_bits6(bin_index_t'(k))];
        end
        verify_windows();
        end_test();

        begin_test("band gain");
        for (int r = 0; r < 5; r++) begin
            band_num = (gain_cases[r].band == 4'd0) ? 16 : int'(gain_cases[r].band);
            base     = 4 * (band_num - 1);
            apb_write(ADDR_CTRL, {gain_cases[r].gain, 8'h00, gain_cases[r].band, 2'b00,
                                  CMD_GAIN}, err);
            if (err) begin
                note_failure($sformatf("gain command %0d refused", r));
            end
            wait_idle("gain command");
            for (int q = 0; q < BAND_SIZE; q++) begin
                mod_exp[base + q] = q15_scale(gain_cases[r].gain, bin_exp[base + q]);
            end
        end
        verify_windows();
        end_test();

        begin_test("inverse feed and capture");
        apb_write(ADDR_CTRL, word_t'(CMD_INVERSE), err);
        if (err) begin
            note_failure("inverse command refused");
        end
        follow_feed(1'b1);
        for (int k = 0; k < NUM_BINS; k++) begin
            rnd          = next_random();
            inv_beats[k] = rnd[15:0];
        end
        play_beats(1'b1);
        wait_idle("inverse capture");
        for (int k = 0; k < NUM_BINS; k++) begin
            result_exp[k] = inv_beats[reverse_bits6(bin_index_t'(k))];
        end
        verify_windows();
        end_test();

        begin_test("error responses");
        // rerun the forward pass with the same beats, poke it while busy
        apb_write(ADDR_CTRL, word_t'(CMD_FORWARD), err);
        if (err) begin
            note_failure("second forward command refused");
        end
        apb_write(ADDR_CTRL, {16'h7fff, 8'h00, 4'd2, 2'b00, CMD_GAIN}, err);
        if (!err) begin
            note_failure("CTRL write while busy gave no pslverr");
        end
        apb_write(window_addr(BASE_SAMPLE, 5), 32'h0000_1111, err);
        if (!err) begin
            note_failure("sample write while busy gave no pslverr");
        end
        apb_read(ADDR_STATUS, rdata, err);
        if (err || rdata !== 32'h1) begin
            note_failure($sformatf("STATUS read %h after refused writes, expected 1", rdata));
        end
        tries = 0;
        while (fwd_in_en && tries < FEED_WAIT) begin
            @(posedge clock);
            #DRIVE_DELAY;
            tries++;
        end
        if (fwd_in_en) begin
            report_timeout("the forward feed to end");
        end
        play_beats(1'b0);
        wait_idle("repeated forward capture");
        for (int r = 0; r < 8; r++) begin
            if (err_cases[r].write) begin
                apb_write(err_cases[r].addr, 32'hffff_a5a5, err);
            end else begin
                apb_read(err_cases[r].addr, rdata, err);
            end
            if (err !== err_cases[r].expect_err) begin
                note_failure($sformatf("pslverr %b at address %h, expected %b",
                                       err, err_cases[r].addr, err_cases[r].expect_err));
            end
        end
        check_entry(ADDR_STATUS, 0, 16'h0000, "STATUS");
        verify_windows();
        end_test();

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+bench
verilog/spectral_pkg.sv
verilog/sample_streamer.sv
verilog/bitrev_capture.sv
verilog/band_gain.sv
verilog/spectral_ctrl.sv
verilog/spectral_top.sv
bench/spectral_tb.sv

// ==== verilog/band_gain.sv ====
// band gain stage
// scales the four bins of one band by a Q15 gain into the MOD
// memory, then streams MOD in natural order to the inverse core
`timescale 1ns/1ps

module band_gain
    import spectral_pkg::*;
(
    input  logic       clock,
    input  logic       fft_reset,
    input  logic       go,
    input  band_t      band,
    input  sample_t    gain,
    output bin_index_t bin_index,
    input  sample_t    bin_value4 [BAND_SIZE],
    input  bin_index_t index,
    output sample_t    rdata,
    input  logic       start,
    output logic       inv_in_en,
    output sample_t    inv_in_im
);

    sample_t             mod_mem [NUM_BINS];
    logic [NUM_BINS-1:0] valid;
    sample_t             scaled [BAND_SIZE];
    bin_index_t          feed_count;

    // band b covers bins 4(b-1)..4(b-1)+3, field 0 wraps to band 16
    assign bin_index = {band_t'(band - 1'b1), 2'b00};

    // Q15 x Q15, keep bits 30:15 of the full product
    for (genvar q = 0; q < BAND_SIZE; q++) begin : g_lane
        logic signed [2*SAMPLE_W-1:0] product;
        assign product   = $signed(gain) * $signed(bin_value4[q]);
        assign scaled[q] = product[2*SAMPLE_W-2:SAMPLE_W-1];
    end

    always_ff @(posedge clock) begin
        if (go) begin
            for (int q = 0; q < BAND_SIZE; q++) begin
                mod_mem[bin_index + bin_index_t'(q)] <= scaled[q];
            end
        end
    end

    // untouched bands read as zero
    always_ff @(posedge clock or posedge fft_reset) begin
        if (fft_reset) begin
            valid <= '0;
        end else if (go) begin
            for (int q = 0; q < BAND_SIZE; q++) begin
                valid[bin_index + bin_index_t'(q)] <= 1'b1;
            end
        end
    end

    assign rdata = valid[index] ? mod_mem[index] : '0;

    // inverse feed, natural order for 64 cycles
    always_ff @(posedge clock or posedge fft_reset) begin
        if (fft_reset) begin
            inv_in_en  <= 1'b0;
            feed_count <= '0;
        end else if (start) begin
            inv_in_en  <= 1'b1;
            feed_count <= '0;
        end else if (inv_in_en) begin
            feed_count <= feed_count + 1'b1;
            if (&feed_count) begin
                inv_in_en <= 1'b0;
            end
        end
    end

    assign inv_in_im = valid[feed_count] ? mod_mem[feed_count] : '0;

endmodule

// ==== verilog/bitrev_capture.sv ====
// bit-reversed stream capture
// once armed, stores 64 accepted beats at bitrev6(beat number),
// pulses full and disarms; also offers a 4-entry band read
`timescale 1ns/1ps

module bitrev_capture
    import spectral_pkg::*;
(
    input  logic       clock,
    input  logic       fft_reset,
    input  logic       arm,
    input  logic       beat_en,
    input  sample_t    beat_data,
    output logic       full,
    input  bin_index_t index,
    output sample_t    rdata,
    input  bin_index_t quad_index,
    output sample_t    quad_rdata [BAND_SIZE]
);

    sample_t             mem [NUM_BINS];
    logic [NUM_BINS-1:0] valid;
    logic                armed;
    bin_index_t          beat_count;
    logic                accept;

    // beats outside an armed window are dropped
    assign accept = armed & beat_en;

    always_ff @(posedge clock or posedge fft_reset) begin
        if (fft_reset) begin
            armed      <= 1'b0;
            beat_count <= '0;
            full       <= 1'b0;
            valid      <= '0;
        end else begin
            full <= 1'b0;
            if (arm) begin
                armed      <= 1'b1;
                beat_count <= '0;
            end else if (accept) begin
                beat_count                <= beat_count + 1'b1;
                valid[bitrev6(beat_count)] <= 1'b1;
                if (&beat_count) begin
                    armed <= 1'b0;
                    full  <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            mem[bitrev6(beat_count)] <= beat_data;
        end
    end

    assign rdata = valid[index] ? mem[index] : '0;

    // four consecutive entries from a band base
    for (genvar q = 0; q < BAND_SIZE; q++) begin : g_quad
        bin_index_t quad_addr;
        assign quad_addr     = quad_index + bin_index_t'(q);
        assign quad_rdata[q] = valid[quad_addr] ? mem[quad_addr] : '0;
    end

endmodule

// ==== verilog/sample_streamer.sv ====
// host-written sample buffer
// 64 entries written over APB, streamed to the forward core
// in index order for 64 cycles after a start pulse
`timescale 1ns/1ps

module sample_streamer
    import spectral_pkg::*;
(
    input  logic       clock,
    input  logic       fft_reset,
    input  logic       we,
    input  bin_index_t index,
    input  sample_t    wdata,
    output sample_t    rdata,
    input  logic       start,
    output logic       fwd_in_en,
    output sample_t    fwd_in_re
);

    sample_t             mem [NUM_BINS];
    logic [NUM_BINS-1:0] valid;
    bin_index_t          feed_count;

    always_ff @(posedge clock) begin
        if (we) begin
            mem[index] <= wdata;
        end
    end

    // entries never written read as zero
    always_ff @(posedge clock or posedge fft_reset) begin
        if (fft_reset) begin
            valid <= '0;
        end else if (we) begin
            valid[index] <= 1'b1;
        end
    end

    assign rdata = valid[index] ? mem[index] : '0;

    // feed counter, one sample per cycle
    always_ff @(posedge clock or posedge fft_reset) begin
        if (fft_reset) begin
            fwd_in_en  <= 1'b0;
            feed_count <= '0;
        end else if (start) begin
            fwd_in_en  <= 1'b1;
            feed_count <= '0;
        end else if (fwd_in_en) begin
            feed_count <= feed_count + 1'b1;
            // last sample leaves with count 63
            if (&feed_count) begin
                fwd_in_en <= 1'b0;
            end
        end
    end

    assign fwd_in_re = valid[feed_count] ? mem[feed_count] : '0;

endmodule

// ==== verilog/spectral_ctrl.sv ====
// spectral path controller
// zero-wait APB slave with register map decode and error response,
// command sequencing FSM and read-data mux over the four memories
`timescale 1ns/1ps

module spectral_ctrl
    import spectral_pkg::*;
(
    input  logic       clock,
    input  logic       fft_reset,
    // APB slave
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  apb_addr_t  paddr,
    input  word_t      pwdata,
    output word_t      prdata,
    output logic       pready,
    output logic       pslverr,
    // memory access
    output logic       sample_we,
    output sample_t    sample_wdata,
    output bin_index_t mem_index,
    input  sample_t    sample_rdata,
    input  sample_t    bin_rdata,
    input  sample_t    mod_rdata,
    input  sample_t    result_rdata,
    // datapath sequencing
    output logic       fwd_start,
    output logic       bin_arm,
    input  logic       bin_full,
    output logic       gain_go,
    output band_t      gain_band,
    output sample_t    gain_value,
    output logic       inv_start,
    output logic       result_arm,
    input  logic       result_full
);

    ctrl_state_t state;
    bin_index_t  phase_count;
    logic        busy;
    logic        access;
    logic        aligned;
    logic        hit_ctrl;
    logic        hit_status;
    logic        hit_sample;
    logic        hit_bin;
    logic        hit_mod;
    logic        hit_result;
    logic        unmapped;
    logic        ro_write;
    logic        busy_write;
    logic        ctrl_write;
    logic [1:0]  cmd;

    assign busy = (state != IDLE);

    // access phase of the two-phase handshake
    assign access  = psel & penable;
    assign aligned = (paddr[1:0] == 2'b00);

    assign hit_ctrl   = (paddr == ADDR_CTRL);
    assign hit_status = (paddr == ADDR_STATUS);
    // windows decode on the top nibble, word index in 7:2
    assign hit_sample = aligned & (paddr[11:8] == BASE_SAMPLE[11:8]);
    assign hit_bin    = aligned & (paddr[11:8] == BASE_BIN[11:8]);
    assign hit_mod    = aligned & (paddr[11:8] == BASE_MOD[11:8]);
    assign hit_result = aligned & (paddr[11:8] == BASE_RESULT[11:8]);

    assign unmapped = ~(hit_ctrl | hit_status | hit_sample | hit_bin | hit_mod | hit_result);

    // read-only targets
    assign ro_write   = pwrite & (hit_status | hit_bin | hit_mod | hit_result);
    // CTRL and sample writes are locked out during a command
    assign busy_write = pwrite & busy & (hit_ctrl | hit_sample);

    // always ready, error only in the access phase
    assign pready  = 1'b1;
    assign pslverr = access & (unmapped | ro_write | busy_write);

    assign ctrl_write = access & pwrite & hit_ctrl & ~busy;
    assign cmd        = pwdata[1:0];

    // shared index for every memory
    assign mem_index    = paddr[7:2];
    assign sample_we    = access & pwrite & hit_sample & ~busy;
    assign sample_wdata = pwdata[SAMPLE_W-1:0];

    // streamer start and capture arm fire together
    assign fwd_start  = ctrl_write & (cmd == CMD_FORWARD);
    assign bin_arm    = fwd_start;
    assign inv_start  = ctrl_write & (cmd == CMD_INVERSE);
    assign result_arm = inv_start;

    // gain write happens in the single GAIN cycle
    assign gain_go = (state == GAIN);

    always_ff @(posedge clock or posedge fft_reset) begin
        if (fft_reset) begin
            state       <= IDLE;
            phase_count <= '0;
            gain_band   <= '0;
            gain_value  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    phase_count <= '0;
                    if (ctrl_write) begin
                        // band and gain fields kept for readback too
                        gain_band  <= pwdata[7:4];
                        gain_value <= pwdata[31:16];
                        case (cmd)
                            CMD_FORWARD: state <= FWD_FEED;
                            CMD_GAIN:    state <= GAIN;
                            CMD_INVERSE: state <= INV_FEED;
                            default:     state <= IDLE;
                        endcase
                    end
                end
                // feed phases track the 64 streamed samples
                FWD_FEED: begin
                    phase_count <= phase_count + 1'b1;
                    if (&phase_count) begin
                        state <= FWD_CAPTURE;
                    end
                end
                FWD_CAPTURE: begin
                    if (bin_full) begin
                        state <= IDLE;
                    end
                end
                GAIN: state <= IDLE;
                INV_FEED: begin
                    phase_count <= phase_count + 1'b1;
                    if (&phase_count) begin
                        state <= INV_CAPTURE;
                    end
                end
                INV_CAPTURE: begin
                    if (result_full) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // read mux, memory entries zero-extended into the word
    always_comb begin
        prdata = '0;
        if (hit_ctrl) begin
            prdata = {gain_value, 8'h00, gain_band, 4'h0};
        end else if (hit_status) begin
            prdata = word_t'(busy);
        end else if (hit_sample) begin
            prdata = word_t'(sample_rdata);
        end else if (hit_bin) begin
            prdata = word_t'(bin_rdata);
        end else if (hit_mod) begin
            prdata = word_t'(mod_rdata);
        end else if (hit_result) begin
            prdata = word_t'(result_rdata);
        end
    end

endmodule

// ==== verilog/spectral_pkg.sv ====
// spectral path shared definitions
// widths, memory sizes, APB register map, command codes,
// control FSM states and the 6-bit bit-reverse helper
package spectral_pkg;

    // basic widths
    localparam int SAMPLE_W = 16;
    localparam int BIN_W    = 6;
    localparam int BAND_W   = 4;

    typedef logic [SAMPLE_W-1:0] sample_t;     // signed Q15 sample, bin or gain
    typedef logic [BIN_W-1:0]    bin_index_t;  // index into a 64-entry memory
    typedef logic [BAND_W-1:0]   band_t;       // band field of CTRL
    typedef logic [11:0]         apb_addr_t;   // APB byte address
    typedef logic [31:0]         word_t;       // APB data word

    localparam int NUM_BINS  = 64;
    localparam int BAND_SIZE = 4;

    // register map, byte offsets
    localparam apb_addr_t ADDR_CTRL   = 12'h000;
    localparam apb_addr_t ADDR_STATUS = 12'h004;
    // memory windows, one word per entry
    localparam apb_addr_t BASE_SAMPLE = 12'h100;
    localparam apb_addr_t BASE_BIN    = 12'h200;
    localparam apb_addr_t BASE_MOD    = 12'h300;
    localparam apb_addr_t BASE_RESULT = 12'h400;

    // CTRL[1:0] command codes
    localparam logic [1:0] CMD_FORWARD = 2'd1;
    localparam logic [1:0] CMD_GAIN    = 2'd2;
    localparam logic [1:0] CMD_INVERSE = 2'd3;

    typedef enum logic [2:0] {
        IDLE,
        FWD_FEED,
        FWD_CAPTURE,
        GAIN,
        INV_FEED,
        INV_CAPTURE
    } ctrl_state_t;

    // mirror the index bits, streaming cores emit in this order
    function automatic bin_index_t bitrev6(input bin_index_t idx);
        bin_index_t rev;
        for (int b = 0; b < BIN_W; b++) begin
            rev[b] = idx[BIN_W-1-b];
        end
        return rev;
    endfunction

endpackage

// ==== verilog/spectral_top.sv ====
// spectral processing top level
// APB-controlled sample buffer, forward FFT capture, band gain
// and inverse FFT capture; both FFT cores sit outside on stream ports
`timescale 1ns/1ps

module spectral_top
    import spectral_pkg::*;
(
    input  logic      clock,
    input  logic      fft_reset,
    // APB slave
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apb_addr_t paddr,
    input  word_t     pwdata,
    output word_t     prdata,
    output logic      pready,
    output logic      pslverr,
    // forward core streams
    output logic      fwd_in_en,
    output sample_t   fwd_in_re,
    input  logic      fwd_out_en,
    input  sample_t   fwd_out_im,
    // inverse core streams
    output logic      inv_in_en,
    output sample_t   inv_in_im,
    input  logic      inv_out_en,
    input  sample_t   inv_out_re
);

    // host side memory access
    logic       sample_we;
    sample_t    sample_wdata;
    bin_index_t mem_index;
    sample_t    sample_rdata;
    sample_t    bin_rdata;
    sample_t    mod_rdata;
    sample_t    result_rdata;

    // sequencing pulses
    logic       fwd_start;
    logic       bin_arm;
    logic       bin_full;
    logic       gain_go;
    band_t      gain_band;
    sample_t    gain_value;
    logic       inv_start;
    logic       result_arm;
    logic       result_full;

    // band read path from the bin capture into the gain stage
    bin_index_t band_base;
    sample_t    band_bins [BAND_SIZE];

    spectral_ctrl i_spectral_ctrl (
        .clock        (clock),
        .fft_reset    (fft_reset),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .sample_we    (sample_we),
        .sample_wdata (sample_wdata),
        .mem_index    (mem_index),
        .sample_rdata (sample_rdata),
        .bin_rdata    (bin_rdata),
        .mod_rdata    (mod_rdata),
        .result_rdata (result_rdata),
        .fwd_start    (fwd_start),
        .bin_arm      (bin_arm),
        .bin_full     (bin_full),
        .gain_go      (gain_go),
        .gain_band    (gain_band),
        .gain_value   (gain_value),
        .inv_start    (inv_start),
        .result_arm   (result_arm),
        .result_full  (result_full)
    );

    sample_streamer i_sample_streamer (
        .clock     (clock),
        .fft_reset (fft_reset),
        .we        (sample_we),
        .index     (mem_index),
        .wdata     (sample_wdata),
        .rdata     (sample_rdata),
        .start     (fwd_start),
        .fwd_in_en (fwd_in_en),
        .fwd_in_re (fwd_in_re)
    );

    // forward core imaginary output lands here
    bitrev_capture bin_cap (
        .clock      (clock),
        .fft_reset  (fft_reset),
        .arm        (bin_arm),
        .beat_en    (fwd_out_en),
        .beat_data  (fwd_out_im),
        .full       (bin_full),
        .index      (mem_index),
        .rdata      (bin_rdata),
        .quad_index (band_base),
        .quad_rdata (band_bins)
    );

    band_gain i_band_gain (
        .clock      (clock),
        .fft_reset  (fft_reset),
        .go         (gain_go),
        .band       (gain_band),
        .gain       (gain_value),
        .bin_index  (band_base),
        .bin_value4 (band_bins),
        .index      (mem_index),
        .rdata      (mod_rdata),
        .start      (inv_start),
        .inv_in_en  (inv_in_en),
        .inv_in_im  (inv_in_im)
    );

    // inverse core real output, band read not needed here
    bitrev_capture result_cap (
        .clock      (clock),
        .fft_reset  (fft_reset),
        .arm        (result_arm),
        .beat_en    (inv_out_en),
        .beat_data  (inv_out_re),
        .full       (result_full),
        .index      (mem_index),
        .rdata      (result_rdata),
        .quad_index (bin_index_t'(0)),
        .quad_rdata ()
    );

endmodule
